// ==== Makefile ====
# Verilator build and run of the zynq glue testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module zynq_glue_tb -Mdir obj_dir -f list.f

# the log decides pass or fail
run: compile
	./obj_dir/Vzynq_glue_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== list.f ====
verilog/zynq_glue_pkg.sv
verilog/csr_bank.sv
verilog/host_window_map.sv
verilog/dram_rebase.sv
verilog/mem_profiler.sv
verilog/zynq_glue_top.sv
tests/zynq_glue_chk.sv
tests/zynq_glue_tb.sv

// ==== tests/zynq_glue_chk.sv ====
`timescale 1ns/10ps

module zynq_glue_chk
  (input  logic                     aclk_i
   , input  logic                   reset_i
   , input  zynq_glue_pkg::csr_wr_s   csr_wr_i
   , input  logic                   csr_rd_v_i
   , input  logic                   csr_rd_v_out_i
   , input  logic                   core_reset_i
   , input  zynq_glue_pkg::host_req_s host_req_i
   , input  zynq_glue_pkg::core_req_s core_req_i
   , input  zynq_glue_pkg::dram_req_s dram_req_i
   , input  zynq_glue_pkg::dram_req_s hp0_req_i
   , input  logic                   hp0_high_i
   );

   import zynq_glue_pkg::*;

   int                err_cnt = 0;
   logic [29:0]       host_bits;
   logic [ADDR_W-1:0] base_q;
   logic [ADDR_W-1:0] dram_off;
   core_req_s         exp_core;
   dram_req_s         exp_hp0;
   logic              exp_high;

   // shadow of the DRAM base register, built from host writes
   always_ff @(posedge aclk_i)
      begin
         if (reset_i)
            base_q <= '0;
         else if (csr_wr_i.v && csr_wr_i.addr == CSR_DRAM_BASE)
            base_q <= csr_wr_i.data;
      end

   assign host_bits = host_req_i.addr;
   assign dram_off  = dram_req_i.addr ^ 32'h8000_0000;

   // bit 29 set means local space, clear means DRAM at 0x8000_0000
   always_comb
      begin
         exp_core          = '0;
         exp_core.v        = 1'b1;
         exp_core.w        = host_req_i.w;
         exp_core.is_local = host_bits[29];
         if (host_bits[29])
            begin
               exp_core.tile = host_bits[27:24];
               exp_core.dev  = host_bits[23:20];
               exp_core.addr = {4'h0, host_bits[27:0]};
            end
         else
            exp_core.addr = {4'h8, host_bits[27:0]};
         exp_hp0      = '0;
         exp_hp0.v    = 1'b1;
         exp_hp0.w    = dram_req_i.w;
         exp_hp0.addr = dram_off + base_q;
         exp_high     = dram_off >= 32'd125829120;
      end

   host_map_a : assert property (@(posedge aclk_i) disable iff (reset_i)
      host_req_i.v |=> core_req_i == $past(exp_core))
      else
         begin
            err_cnt++;
            $error("core request does not match the translated host request");
         end

   dram_rebase_a : assert property (@(posedge aclk_i) disable iff (reset_i)
      dram_req_i.v |=> hp0_req_i == $past(exp_hp0) && hp0_high_i == $past(exp_high))
      else
         begin
            err_cnt++;
            $error("hp0 request or high flag does not match the rebased DRAM request");
         end

   rd_valid_a : assert property (@(posedge aclk_i) disable iff (reset_i)
      csr_rd_v_i |=> csr_rd_v_out_i)
      else
         begin
            err_cnt++;
            $error("register read returned no valid one cycle after the strobe");
         end

   rd_idle_a : assert property (@(posedge aclk_i) disable iff (reset_i)
      !csr_rd_v_i |=> !csr_rd_v_out_i)
      else
         begin
            err_cnt++;
            $error("register read valid without a read strobe");
         end

   core_reset_a : assert property (@(posedge aclk_i)
      reset_i |=> core_reset_i)
      else
         begin
            err_cnt++;
            $error("core reset low in the cycle after system reset");
         end

endmodule

bind zynq_glue_top zynq_glue_chk chk0
  (.aclk_i          (aclk_i)
   ,.reset_i        (reset_i)
   ,.csr_wr_i       (csr_wr_i)
   ,.csr_rd_v_i     (csr_rd_v_i)
   ,.csr_rd_v_out_i (csr_rd_v_o)
   ,.core_reset_i   (core_reset_o)
   ,.host_req_i     (host_req_i)
   ,.core_req_i     (core_req_o)
   ,.dram_req_i     (core_dram_req_i)
   ,.hp0_req_i      (hp0_req_o)
   ,.hp0_high_i     (hp0_high_o)
   );

// ==== tests/zynq_glue_tb.sv ====
`timescale 1ns/10ps

module zynq_glue_tb;

   import zynq_glue_pkg::*;

   logic                  aclk_i;
   logic                  reset_i;
   csr_wr_s               csr_wr_i;
   logic                  csr_rd_v_i;
   logic [CSR_ADDR_W-1:0] csr_rd_addr_i;
   host_req_s             host_req_i;
   dram_req_s             core_dram_req_i;
   logic [DATA_W-1:0]     csr_rd_data_o;
   logic                  csr_rd_v_o;
   logic                  core_reset_o;
   core_req_s             core_req_o;
   dram_req_s             hp0_req_o;
   logic                  hp0_high_o;

   int errors;
   int tests_failed;
   int err_mark;

   zynq_glue_top dut0 (.*);

   always #4 aclk_i = ~aclk_i;

   // includes the failures of the bound checker
   function automatic int total_errors();
      return errors + dut0.chk0.err_cnt;
   endfunction

   task automatic write_reg(input logic [CSR_ADDR_W-1:0] idx, input logic [DATA_W-1:0] data);
      csr_wr_i.v    = 1'b1;
      csr_wr_i.addr = idx;
      csr_wr_i.data = data;
      @(negedge aclk_i);
      csr_wr_i = '0;
   endtask

   task automatic read_expect(input logic [CSR_ADDR_W-1:0] idx, input logic [DATA_W-1:0] exp);
      int waited;
      waited        = 0;
      csr_rd_v_i    = 1'b1;
      csr_rd_addr_i = idx;
      @(negedge aclk_i);
      csr_rd_v_i = 1'b0;
      while (!csr_rd_v_o && waited < 20)
         begin
            @(negedge aclk_i);
            waited++;
         end
      if (!csr_rd_v_o)
         begin
            $display("timeout: no read data returned for register %0d", idx);
            errors++;
         end
      else
         assert (csr_rd_data_o == exp)
         else
            begin
               $display("MISMATCH at %0t: register %0d read 0x%08h, expected 0x%08h",
                        $time, idx, csr_rd_data_o, exp);
               errors++;
            end
   endtask

   task automatic wait_core_reset(input logic level, input int exp_cycles);
      int waited;
      waited = 0;
      while (core_reset_o != level && waited < 20)
         begin
            @(negedge aclk_i);
            waited++;
         end
      if (core_reset_o != level)
         begin
            $display("timeout: core reset never reached level %0d", level);
            errors++;
         end
      else
         assert (waited == exp_cycles)
         else
            begin
               $display("MISMATCH at %0t: core reset moved after %0d cycles, expected %0d",
                        $time, waited, exp_cycles);
               errors++;
            end
   endtask

   task automatic send_host(input logic sel, input logic [27:0] off);
      host_req_i.v    = 1'b1;
      host_req_i.w    = 1'($urandom);
      host_req_i.addr = {sel, 1'($urandom), off};
      @(negedge aclk_i);
      host_req_i = '0;
   endtask

   task automatic send_dram(input logic [ADDR_W-1:0] addr);
      core_dram_req_i.v    = 1'b1;
      core_dram_req_i.w    = 1'($urandom);
      core_dram_req_i.addr = addr;
      @(negedge aclk_i);
      core_dram_req_i = '0;
   endtask

   // the high flag comes out with the request, one cycle later
   task automatic check_high_flag(input logic [ADDR_W-1:0] offset);
      logic exp_high;
      exp_high = offset >= 32'd125829120;
      send_dram(32'h8000_0000 | offset);
      assert (hp0_req_o.v && hp0_high_o == exp_high)
      else
         begin
            $display("MISMATCH at %0t: offset 0x%08h gave high flag %0d, expected %0d",
                     $time, offset, hp0_high_o, exp_high);
            errors++;
         end
   endtask

   // let pending outputs settle so the checker sees every request
   task automatic drain_outputs();
      int waited;
      waited = 0;
      while ((core_req_o.v || hp0_req_o.v || csr_rd_v_o) && waited < 20)
         begin
            @(negedge aclk_i);
            waited++;
         end
      if (core_req_o.v || hp0_req_o.v || csr_rd_v_o)
         begin
            $display("timeout: DUT outputs stayed valid");
            errors++;
         end
      @(negedge aclk_i);
   endtask

   task automatic report_test(input int num, input string name);
      if (total_errors() != err_mark)
         begin
            tests_failed++;
            $display("test %0d %s: FAIL", num, name);
         end
      else
         $display("test %0d %s: ok", num, name);
      err_mark = total_errors();
   endtask

   initial
      begin
         logic [DATA_W-1:0] base;
         logic [PROF_W-1:0] exp_prof;
         logic [6:0]        region;
         int                i;
         void'($urandom(32'h7810));
         aclk_i          = 1'b0;
         reset_i         = 1'b1;
         csr_wr_i        = '0;
         csr_rd_v_i      = 1'b0;
         csr_rd_addr_i   = '0;
         host_req_i      = '0;
         core_dram_req_i = '0;
         errors          = 0;
         tests_failed    = 0;
         err_mark        = 0;
         repeat (10) @(negedge aclk_i);
         reset_i = 1'b0;

         assert (core_reset_o && !core_req_o.v && !hp0_req_o.v && !csr_rd_v_o)
         else
            begin
               $display("MISMATCH at %0t: outputs not idle after reset", $time);
               errors++;
            end
         read_expect(CSR_RUN, '0);
         read_expect(CSR_DRAM_ALLOC, '0);
         read_expect(CSR_DRAM_BASE, '0);
         write_reg(CSR_RUN, 32'd1);
         wait_core_reset(1'b0, 1);
         read_expect(CSR_RUN, 32'd1);
         write_reg(CSR_RUN, 32'd0);
         wait_core_reset(1'b1, 1);
         write_reg(CSR_DRAM_ALLOC, 32'd1);
         read_expect(CSR_DRAM_ALLOC, 32'd1);
         drain_outputs();
         report_test(1, "reset and run bit");

         // back-to-back requests over both windows
         for (i = 0; i < 24; i++)
            send_host(1'($urandom), 28'($urandom));
         drain_outputs();
         report_test(2, "host window map");

         // requests follow the base write at once, so the new base must already apply
         base = $urandom;
         write_reg(CSR_DRAM_BASE, base);
         for (i = 0; i < 16; i++)
            send_dram(32'h8000_0000 | ($urandom % 32'd125829120));
         read_expect(CSR_DRAM_BASE, base);
         // unmapped word
         read_expect(CSR_ADDR_W'(3), '0);
         drain_outputs();
         report_test(3, "dram rebase");

         check_high_flag(32'd125829120 - 32'd1);
         check_high_flag(32'd125829120);
         check_high_flag(32'd125829120 + 32'(24'($urandom)));
         check_high_flag(32'd0);
         drain_outputs();
         report_test(4, "high address flag");

         write_reg(CSR_RUN, 32'd1);
         wait_core_reset(1'b0, 1);
         exp_prof = '0;
         for (i = 0; i < 8; i++)
            begin
               region           = (i == 0) ? 7'd0 : (i == 1) ? 7'd127 : 7'($urandom);
               exp_prof[region] = 1'b1;
               send_dram(32'h8000_0000 | (32'(region) << 23) | 32'(23'($urandom)));
            end
         for (i = 0; i < 4; i++)
            read_expect(CSR_PROF0 + CSR_ADDR_W'(i), exp_prof[i*32 +: 32]);
         // a pass through core reset empties the bitmap
         write_reg(CSR_RUN, 32'd0);
         wait_core_reset(1'b1, 1);
         write_reg(CSR_RUN, 32'd1);
         wait_core_reset(1'b0, 1);
         for (i = 0; i < 4; i++)
            read_expect(CSR_PROF0 + CSR_ADDR_W'(i), '0);
         drain_outputs();
         report_test(5, "memory profiler");

         $display("tests run 5, tests failed %0d, errors %0d", tests_failed, total_errors());
         if (tests_failed == 0 && total_errors() == 0)
            $display("Testbench passed");
         else
            $display("Testbench failed");
         $finish;
      end

endmodule

// ==== verilog/csr_bank.sv ====
`timescale 1ns/10ps

module csr_bank
  (input  logic                                  aclk_i
   , input  logic                                reset_i
   , input  zynq_glue_pkg::csr_wr_s              csr_wr_i
   , input  logic                                csr_rd_v_i
   , input  logic [zynq_glue_pkg::CSR_ADDR_W-1:0] csr_rd_addr_i
   , input  logic [zynq_glue_pkg::PROF_W-1:0]     prof_i
   , output logic [zynq_glue_pkg::DATA_W-1:0]     csr_rd_data_o
   , output logic                                csr_rd_v_o
   , output logic [zynq_glue_pkg::ADDR_W-1:0]     dram_base_o
   , output logic                                core_reset_o
   );

   import zynq_glue_pkg::*;

   logic                                    run_r;
   logic                                    dram_alloc_r;
   logic [ADDR_W-1:0]                       dram_base_r;
   logic [PROF_W/DATA_W-1:0][DATA_W-1:0]    prof_words;
   logic [DATA_W-1:0]                       rd_word;
   logic [DATA_W-1:0]                       rd_data_r;
   logic                                    rd_v_r;
   logic                                    core_reset_r;

   // host writes land at the sampling edge
   always_ff @(posedge aclk_i)
      begin
         if (reset_i)
            begin
               run_r        <= 1'b0;
               dram_alloc_r <= 1'b0;
               dram_base_r  <= '0;
            end
         else if (csr_wr_i.v)
            begin
               if (csr_wr_i.addr == CSR_RUN)
                  run_r <= csr_wr_i.data[0];
               if (csr_wr_i.addr == CSR_DRAM_ALLOC)
                  dram_alloc_r <= csr_wr_i.data[0];
               if (csr_wr_i.addr == CSR_DRAM_BASE)
                  dram_base_r <= csr_wr_i.data;
            end
      end

   assign prof_words = prof_i;

   // readback mux, unmapped words read as zero
   always_comb
      begin
         rd_word = '0;
         if (csr_rd_addr_i == CSR_RUN)
            rd_word = DATA_W'(run_r);
         else if (csr_rd_addr_i == CSR_DRAM_ALLOC)
            rd_word = DATA_W'(dram_alloc_r);
         else if (csr_rd_addr_i == CSR_DRAM_BASE)
            rd_word = dram_base_r;
         else if (csr_rd_addr_i[CSR_ADDR_W-1:2] == CSR_PROF0[CSR_ADDR_W-1:2])
            rd_word = prof_words[csr_rd_addr_i[1:0]];
      end

   always_ff @(posedge aclk_i)
      begin
         if (reset_i)
            rd_v_r <= 1'b0;
         else
            rd_v_r <= csr_rd_v_i;
         if (csr_rd_v_i)
            rd_data_r <= rd_word;
      end

   // core stays in reset until the host sets the run bit
   always_ff @(posedge aclk_i)
      begin
         if (reset_i)
            core_reset_r <= 1'b1;
         else
            core_reset_r <= ~run_r;
      end

   assign csr_rd_data_o = rd_data_r;
   assign csr_rd_v_o    = rd_v_r;
   assign dram_base_o   = dram_base_r;
   assign core_reset_o  = core_reset_r;

endmodule

// ==== verilog/dram_rebase.sv ====
`timescale 1ns/10ps

module dram_rebase
  (input  logic                              aclk_i
   , input  logic                            reset_i
   , input  zynq_glue_pkg::dram_req_s          core_dram_req_i
   , input  logic [zynq_glue_pkg::ADDR_W-1:0] dram_base_i
   , output zynq_glue_pkg::dram_req_s          hp0_req_o
   , output logic                            hp0_high_o
   );

   import zynq_glue_pkg::*;

   logic [ADDR_W-1:0] offset;
   logic              high_n;
   dram_req_s         req_r;
   logic              high_r;

   // xor strips the core DRAM base bit, the PS allocation base is added back
   assign offset = core_dram_req_i.addr ^ CORE_DRAM_BASE;

   // anything past the allocated window is flagged
   assign high_n = core_dram_req_i.v && (offset >= DRAM_LIMIT);

   always_ff @(posedge aclk_i)
      begin
         if (reset_i)
            begin
               req_r.v <= 1'b0;
               high_r  <= 1'b0;
            end
         else
            begin
               req_r.v <= core_dram_req_i.v;
               high_r  <= high_n;
            end
         if (core_dram_req_i.v)
            begin
               req_r.w    <= core_dram_req_i.w;
               req_r.addr <= offset + dram_base_i;
            end
      end

   assign hp0_req_o  = req_r;
   assign hp0_high_o = high_r;

endmodule

// ==== verilog/host_window_map.sv ====
`timescale 1ns/10ps

module host_window_map
  (input  logic                     aclk_i
   , input  logic                   reset_i
   , input  zynq_glue_pkg::host_req_s host_req_i
   , output zynq_glue_pkg::core_req_s core_req_o
   );

   import zynq_glue_pkg::*;

   host_addr_u haddr;
   core_req_s  req_n;
   core_req_s  req_r;

   assign haddr = host_req_i.addr;

   always_comb
      begin
         req_n   = '0;
         req_n.v = host_req_i.v;
         req_n.w = host_req_i.w;
         if (!haddr.dram_view.sel)
            begin
               // GP1 0x0xxx_xxxx lands in core DRAM at 0x8xxx_xxxx
               req_n.addr = CORE_DRAM_BASE + ADDR_W'(haddr.dram_view.off);
            end
         else
            begin
               // GP1 0x2xxx_xxxx lands in core local space
               req_n.is_local = 1'b1;
               req_n.tile     = haddr.local_view.tile;
               req_n.dev      = haddr.local_view.dev;
               req_n.addr     = ADDR_W'({haddr.local_view.tile,
                                         haddr.local_view.dev,
                                         haddr.local_view.off});
            end
      end

   // one stage, the payload only moves with a valid request
   always_ff @(posedge aclk_i)
      begin
         if (reset_i)
            req_r.v <= 1'b0;
         else if (req_n.v)
            req_r <= req_n;
         else
            req_r.v <= 1'b0;
      end

   assign core_req_o = req_r;

endmodule

// ==== verilog/mem_profiler.sv ====
`timescale 1ns/10ps

module mem_profiler
  (input  logic                             aclk_i
   , input  logic                           core_reset_i
   , input  zynq_glue_pkg::dram_req_s         core_dram_req_i
   , output logic [zynq_glue_pkg::PROF_W-1:0] prof_o
   );

   import zynq_glue_pkg::*;

   logic [$clog2(PROF_W)-1:0] region;
   logic [PROF_W-1:0]         prof_r;

   // 8 MB granule taken from address bits 29:23
   assign region = core_dram_req_i.addr[PROF_LSB +: $clog2(PROF_W)];

   // bits are sticky until the core goes back into reset
   always_ff @(posedge aclk_i)
      begin
         if (core_reset_i)
            prof_r <= '0;
         else if (core_dram_req_i.v)
            prof_r[region] <= 1'b1;
      end

   assign prof_o = prof_r;

endmodule

// ==== verilog/zynq_glue_pkg.sv ====
package zynq_glue_pkg;

   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int CSR_ADDR_W = 4;

   // host register word indices, profiler spans 8..11
   localparam logic [CSR_ADDR_W-1:0] CSR_RUN        = CSR_ADDR_W'(0);
   localparam logic [CSR_ADDR_W-1:0] CSR_DRAM_ALLOC = CSR_ADDR_W'(1);
   localparam logic [CSR_ADDR_W-1:0] CSR_DRAM_BASE  = CSR_ADDR_W'(2);
   localparam logic [CSR_ADDR_W-1:0] CSR_PROF0      = CSR_ADDR_W'(8);

   localparam logic [ADDR_W-1:0] CORE_DRAM_BASE = 32'h8000_0000;
   localparam logic [ADDR_W-1:0] DRAM_LIMIT     = ADDR_W'(120 * 1024 * 1024);

   // one bit per 8 MB region, index is address bits 29:23
   localparam int PROF_W   = 128;
   localparam int PROF_LSB = 23;

   typedef struct packed {
      logic                  v;
      logic [CSR_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     data;
   } csr_wr_s;

   // bit 29 picks the DRAM window (0) or the local window (1)
   typedef struct packed {
      logic        sel;
      logic        pad;
      logic [27:0] off;
   } host_dram_view_s;

   typedef struct packed {
      logic        sel;
      logic        pad;
      logic [3:0]  tile;
      logic [3:0]  dev;
      logic [19:0] off;
   } host_local_view_s;

   typedef union packed {
      host_dram_view_s  dram_view;
      host_local_view_s local_view;
   } host_addr_u;

   typedef struct packed {
      logic       v;
      logic       w;
      host_addr_u addr;
   } host_req_s;

   typedef struct packed {
      logic              v;
      logic              w;
      logic              is_local;
      logic [3:0]        tile;
      logic [3:0]        dev;
      logic [ADDR_W-1:0] addr;
   } core_req_s;

   typedef struct packed {
      logic              v;
      logic              w;
      logic [ADDR_W-1:0] addr;
   } dram_req_s;

endpackage

// ==== verilog/zynq_glue_top.sv ====
`timescale 1ns/10ps

module zynq_glue_top
  (input  logic                                  aclk_i
   , input  logic                                reset_i
   , input  zynq_glue_pkg::csr_wr_s              csr_wr_i
   , input  logic                                csr_rd_v_i
   , input  logic [zynq_glue_pkg::CSR_ADDR_W-1:0] csr_rd_addr_i
   , input  zynq_glue_pkg::host_req_s            host_req_i
   , input  zynq_glue_pkg::dram_req_s            core_dram_req_i
   , output logic [zynq_glue_pkg::DATA_W-1:0]     csr_rd_data_o
   , output logic                                csr_rd_v_o
   , output logic                                core_reset_o
   , output zynq_glue_pkg::core_req_s            core_req_o
   , output zynq_glue_pkg::dram_req_s            hp0_req_o
   , output logic                                hp0_high_o
   );

   import zynq_glue_pkg::*;

   logic [ADDR_W-1:0] dram_base;
   logic [PROF_W-1:0] prof;

   // host register bank and core reset
   csr_bank csr0
     (.aclk_i         (aclk_i)
      ,.reset_i       (reset_i)
      ,.csr_wr_i      (csr_wr_i)
      ,.csr_rd_v_i    (csr_rd_v_i)
      ,.csr_rd_addr_i (csr_rd_addr_i)
      ,.prof_i        (prof)
      ,.csr_rd_data_o (csr_rd_data_o)
      ,.csr_rd_v_o    (csr_rd_v_o)
      ,.dram_base_o   (dram_base)
      ,.core_reset_o  (core_reset_o)
      );

   // host GP1 window into core space
   host_window_map map0
     (.aclk_i      (aclk_i)
      ,.reset_i    (reset_i)
      ,.host_req_i (host_req_i)
      ,.core_req_o (core_req_o)
      );

   // core DRAM into the PS allocation
   dram_rebase rebase0
     (.aclk_i           (aclk_i)
      ,.reset_i         (reset_i)
      ,.core_dram_req_i (core_dram_req_i)
      ,.dram_base_i     (dram_base)
      ,.hp0_req_o       (hp0_req_o)
      ,.hp0_high_o      (hp0_high_o)
      );

   // profiler lives in the core reset domain
   mem_profiler prof0
     (.aclk_i           (aclk_i)
      ,.core_reset_i    (core_reset_o)
      ,.core_dram_req_i (core_dram_req_i)
      ,.prof_o          (prof)
      );

endmodule
